/* Makefile */
OBJ = obj_dir

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_icache \
		-f filelist.f -Mdir $(OBJ) -o sim
	./$(OBJ)/sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

lint:
	verilator --lint-only -Wall --timing --top-module icache_top -f filelist.f

clean:
	rm -rf $(OBJ)

/* common/icache_defines.svh */
/*
  instruction cache geometry macros
*/

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// associativity and number of sets
`define ICACHE_WAYS       4
`define ICACHE_SETS       16

// 32-bit words per cache line
`define ICACHE_LINE_WORDS 4

// physical address and fetch word widths
`define ICACHE_ADDR_W     32
`define ICACHE_FETCH_W    32

// replacement lfsr
`define ICACHE_LFSR_W     8

`endif

/* common/icache_pkg.sv */
/*
  icache types for address, tag, line and way, plus the address split helper
*/

`include "icache_defines.svh"

package icache_pkg;

  // derived field widths of a physical address
  localparam int unsigned BYTE_W     = $clog2(`ICACHE_FETCH_W / 8);
  localparam int unsigned OFF_W      = $clog2(`ICACHE_LINE_WORDS);
  localparam int unsigned IDX_W      = $clog2(`ICACHE_SETS);
  localparam int unsigned TAG_W      = `ICACHE_ADDR_W - IDX_W - OFF_W - BYTE_W;
  localparam int unsigned LINE_OFF_W = OFF_W + BYTE_W;
  localparam int unsigned WAY_IDX_W  = $clog2(`ICACHE_WAYS);

  typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
  typedef logic [`ICACHE_FETCH_W-1:0] word_t;
  // a line is indexed by word offset
  typedef word_t [`ICACHE_LINE_WORDS-1:0] line_t;
  typedef logic [IDX_W-1:0]           index_t;
  typedef logic [OFF_W-1:0]           offset_t;
  typedef logic [TAG_W-1:0]           tag_t;
  typedef logic [WAY_IDX_W-1:0]       way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]    way_oh_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // per-way lookup result
  typedef struct packed {
    logic  hit;
    logic  valid;
    word_t word;
  } way_rsp_t;

  // tag | index | word offset | byte offset
  function automatic void split_addr(input addr_t addr, output tag_t tag,
                                     output index_t index, output offset_t offset);
    tag    = addr[`ICACHE_ADDR_W-1 -: TAG_W];
    index  = addr[LINE_OFF_W +: IDX_W];
    offset = addr[BYTE_W +: OFF_W];
  endfunction

endpackage

/* common/icache_way_if.sv */
/*
  array access bundle from the controller to every cache way
*/

`timescale 1ns/100ps

interface icache_way_if;
  import icache_pkg::*;

  // lookup strobe, all ways read the same set
  logic    rd_en;
  // refill write into the selected way
  logic    wr_en;
  // flush clear of one set in every way
  logic    clr_en;
  index_t  index;
  // tag of the fetch in flight, also written on a fill
  tag_t    cmp_tag;
  offset_t offset;
  line_t   fill_line;
  // write select, one bit per way
  way_oh_t wr_way_oh;

  modport ctrl_mp (
    output rd_en, wr_en, clr_en, index, cmp_tag, offset, fill_line, wr_way_oh
  );

  modport way_mp (
    input rd_en, wr_en, clr_en, index, cmp_tag, offset, fill_line, wr_way_oh
  );

endinterface

/* filelist.f */
+incdir+common
common/icache_pkg.sv
common/icache_way_if.sv
logic/icache_sram.sv
logic/icache_repl.sv
logic/icache_hit_mux.sv
icache/icache_way.sv
icache/icache_ctrl.sv
icache/icache_top.sv
tb/icache_sva.sv
tb/tb_icache.sv

/* icache/icache_ctrl.sv */
/*
  icache controller: flush/idle/read/miss fsm, fetch address registers,
  flush counter and the fetch data mux
*/

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  logic                flush_i,
  // fetch side
  input  logic                req_i,
  input  icache_pkg::addr_t   addr_i,
  output logic                ready_o,
  output logic                valid_o,
  output icache_pkg::word_t   data_o,
  output logic                busy_o,
  output logic                miss_o,
  // memory side
  output logic                mem_req_o,
  output icache_pkg::addr_t   mem_addr_o,
  output logic                mem_nc_o,
  input  logic                mem_rtrn_vld_i,
  input  icache_pkg::line_t   mem_rtrn_line_i,
  // ways, hit mux and replacement
  input  logic                hit_i,
  input  icache_pkg::word_t   hit_data_i,
  input  icache_pkg::way_oh_t repl_way_oh_i,
  output logic                fill_o,
  icache_way_if.ctrl_mp       way_bus
);
  import icache_pkg::*;

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e  state_d, state_q;
  logic    en_d, en_q;
  logic    flush_d, flush_q;
  // second read cycle, the way responses are valid
  logic    lookup_d, lookup_q;
  // fetch in flight goes around the arrays
  logic    nc_d, nc_q;
  index_t  flush_cnt_d, flush_cnt_q;
  logic    flush_done;
  logic    cache_en, flush_req, en_rise, accept;

  // fetch address fields, split on the way in
  tag_t    req_tag, tag_q;
  index_t  req_index, index_q;
  offset_t req_offset, offset_q;

  always_comb begin
    split_addr(addr_i, req_tag, req_index, req_offset);
  end

  // dropping en_i counts in this very cycle
  assign cache_en   = en_q & en_i;
  assign flush_req  = flush_q | flush_i;
  // enabling again goes through a flush first
  assign en_rise    = en_i & ~en_q;
  assign flush_done = (flush_cnt_q == index_t'(`ICACHE_SETS - 1));
  assign busy_o     = (state_q == FLUSH);

  //////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    en_d          = cache_en;
    flush_d       = flush_req;
    lookup_d      = 1'b0;
    nc_d          = nc_q;
    flush_cnt_d   = flush_cnt_q;
    ready_o       = 1'b0;
    valid_o       = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    fill_o        = 1'b0;
    accept        = 1'b0;
    way_bus.rd_en = 1'b0;

    unique case (state_q)
      // walk all sets, clearing every way
      FLUSH: begin
        if (flush_done) begin
          state_d     = IDLE;
          flush_cnt_d = '0;
          flush_d     = 1'b0;
          en_d        = en_i;
        end else begin
          flush_cnt_d = flush_cnt_q + 1'b1;
        end
      end
      IDLE: begin
        if (flush_req || en_rise) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            accept        = 1'b1;
            // no array read when the cache is off
            way_bus.rd_en = cache_en;
            state_d       = READ;
          end
        end
      end
      READ: begin
        if (!lookup_q) begin
          // arrays answer, ways register the compare
          lookup_d = 1'b1;
        end else if (cache_en && hit_i) begin
          valid_o = 1'b1;
          state_d = IDLE;
          // next fetch reads while this one returns
          if (!flush_req) begin
            ready_o = 1'b1;
            if (req_i) begin
              accept        = 1'b1;
              way_bus.rd_en = 1'b1;
              state_d       = READ;
            end
          end
        end else begin
          // cached miss or uncached word
          mem_req_o = 1'b1;
          miss_o    = cache_en;
          nc_d      = ~cache_en;
          state_d   = MISS;
        end
      end
      MISS: begin
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          fill_o  = ~nc_q;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // array bus and memory request
  //////////////////////////////////////////////////

  // flush counter, new fetch, or the fetch in flight
  assign way_bus.index     = (state_q == FLUSH) ? flush_cnt_q :
                             accept             ? req_index   : index_q;
  assign way_bus.cmp_tag   = tag_q;
  assign way_bus.offset    = offset_q;
  assign way_bus.wr_en     = fill_o;
  assign way_bus.clr_en    = (state_q == FLUSH);
  assign way_bus.fill_line = mem_rtrn_line_i;
  assign way_bus.wr_way_oh = (state_q == FLUSH) ? '1 : repl_way_oh_i;

  // line-aligned for a refill, word-aligned when uncached
  assign mem_nc_o   = ~cache_en;
  assign mem_addr_o = cache_en ? {tag_q, index_q, {LINE_OFF_W{1'b0}}} :
                                 {tag_q, index_q, offset_q, {BYTE_W{1'b0}}};

  // memory returns the whole line holding mem_addr_o
  assign data_o = (state_q == MISS) ? mem_rtrn_line_i[offset_q] : hit_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      en_q        <= 1'b0;
      flush_q     <= 1'b0;
      lookup_q    <= 1'b0;
      nc_q        <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      en_q        <= en_d;
      flush_q     <= flush_d;
      lookup_q    <= lookup_d;
      nc_q        <= nc_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  // fetch address, loaded on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q    <= req_tag;
      index_q  <= req_index;
      offset_q <= req_offset;
    end
  end

endmodule

/* icache/icache_top.sv */
/*
  icache top level: controller, ways, hit mux and replacement logic
*/

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  logic                flush_i,
  // fetch side
  input  logic                req_i,
  input  icache_pkg::addr_t   addr_i,
  output logic                ready_o,
  output logic                valid_o,
  output icache_pkg::word_t   data_o,
  output logic                busy_o,
  output logic                miss_o,
  // memory side
  output logic                mem_req_o,
  output icache_pkg::addr_t   mem_addr_o,
  output logic                mem_nc_o,
  input  logic                mem_rtrn_vld_i,
  input  icache_pkg::line_t   mem_rtrn_line_i
);
  import icache_pkg::*;

  icache_way_if way_bus ();

  // per-way responses, drained by the hit mux and the replacement logic
  way_rsp_t way_rsp [`ICACHE_WAYS];
  way_oh_t  way_valid;
  way_oh_t  repl_way_oh;
  logic     hit;
  word_t    hit_data;
  logic     fill;

  icache_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .data_o          (data_o),
    .busy_o          (busy_o),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_line_i (mem_rtrn_line_i),
    .hit_i           (hit),
    .hit_data_i      (hit_data),
    .repl_way_oh_i   (repl_way_oh),
    .fill_o          (fill),
    .way_bus         (way_bus)
  );

  for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : gen_way
    icache_way u_way (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .way_bus   (way_bus),
      .way_sel_i (way_bus.wr_way_oh[g]),
      .rsp_o     (way_rsp[g])
    );

    assign way_valid[g] = way_rsp[g].valid;
  end

  icache_hit_mux u_hit_mux (
    .rsp_i  (way_rsp),
    .hit_o  (hit),
    .data_o (hit_data)
  );

  icache_repl u_repl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (way_valid),
    .fill_i        (fill),
    .repl_way_oh_o (repl_way_oh)
  );

endmodule

/* icache/icache_way.sv */
/*
  one cache way: tag+valid array, data array, tag compare, word select
*/

`timescale 1ns/100ps

module icache_way (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  icache_way_if.way_mp         way_bus,
  input  logic                 way_sel_i,
  output icache_pkg::way_rsp_t rsp_o
);
  import icache_pkg::*;

  tag_entry_t tag_wdata;
  tag_entry_t tag_rdata;
  line_t      line_rdata;
  logic       tag_req, tag_we;
  logic       data_req, data_we;
  // array outputs hold fresh read data
  logic       rd_q;
  way_rsp_t   rsp_d;

  // fill sets valid, flush clears it
  assign tag_we          = way_sel_i & (way_bus.wr_en | way_bus.clr_en);
  assign tag_req         = way_bus.rd_en | tag_we;
  assign tag_wdata.valid = way_bus.wr_en;
  assign tag_wdata.tag   = way_bus.cmp_tag;

  // data is only written on a fill
  assign data_we  = way_sel_i & way_bus.wr_en;
  assign data_req = way_bus.rd_en | data_we;

  icache_sram #(
    .entry_t (tag_entry_t)
  ) u_tag_sram (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (tag_req),
    .we_i    (tag_we),
    .addr_i  (way_bus.index),
    .wdata_i (tag_wdata),
    .rdata_o (tag_rdata)
  );

  icache_sram #(
    .entry_t (line_t)
  ) u_data_sram (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (data_req),
    .we_i    (data_we),
    .addr_i  (way_bus.index),
    .wdata_i (way_bus.fill_line),
    .rdata_o (line_rdata)
  );

  // compare against the registered fetch tag
  assign rsp_d.valid = tag_rdata.valid;
  assign rsp_d.hit   = tag_rdata.valid && (tag_rdata.tag == way_bus.cmp_tag);
  assign rsp_d.word  = line_rdata[way_bus.offset];

  // response holds until the next lookup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q  <= 1'b0;
      rsp_o <= '0;
    end else begin
      rd_q <= way_bus.rd_en;
      if (rd_q) begin
        rsp_o <= rsp_d;
      end
    end
  end

endmodule

/* logic/icache_hit_mux.sv */
/*
  hit mux: word of the lowest hitting way and the hit flag
*/

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_hit_mux (
  input  icache_pkg::way_rsp_t rsp_i [`ICACHE_WAYS],
  output logic                 hit_o,
  output icache_pkg::word_t    data_o
);

  //////////////////////////////////////////////////
  // priority select
  //////////////////////////////////////////////////

  // scan down so the lowest hitting way wins
  always_comb begin
    hit_o  = 1'b0;
    data_o = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (rsp_i[i].hit) begin
        hit_o  = 1'b1;
        data_o = rsp_i[i].word;
      end
    end
  end

endmodule

/* logic/icache_repl.sv */
/*
  replacement way: lowest invalid way, else an lfsr pick
*/

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_repl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  icache_pkg::way_oh_t valid_i,
  input  logic                fill_i,
  output icache_pkg::way_oh_t repl_way_oh_o
);
  import icache_pkg::*;

  logic [`ICACHE_LFSR_W-1:0] lfsr_d, lfsr_q;
  way_idx_t                  inv_way;
  way_idx_t                  pick_way;
  logic                      all_valid;
  way_oh_t                   repl_way_oh_d;

  // scan down so the lowest invalid way wins
  always_comb begin
    inv_way = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        inv_way = way_idx_t'(i);
      end
    end
  end

  assign all_valid     = &valid_i;
  assign pick_way      = all_valid ? way_idx_t'(lfsr_q) : inv_way;
  assign repl_way_oh_d = way_oh_t'(1) << pick_way;

  // fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_d = {lfsr_q[`ICACHE_LFSR_W-2:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q        <= {{(`ICACHE_LFSR_W - 1){1'b0}}, 1'b1};
      repl_way_oh_o <= way_oh_t'(1);
    end else begin
      // advance only when a full set loses a line
      if (fill_i && all_valid) begin
        lfsr_q <= lfsr_d;
      end
      // valid bits hold through the miss, so does the choice
      if (!fill_i) begin
        repl_way_oh_o <= repl_way_oh_d;
      end
    end
  end

endmodule

/* logic/icache_sram.sv */
/*
  synchronous single-port array, one entry per set
*/

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_sram #(
  parameter type entry_t = logic
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  icache_pkg::index_t addr_i,
  input  entry_t             wdata_i,
  output entry_t             rdata_o
);

  entry_t mem_q [`ICACHE_SETS];

  // array write
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // registered read port, holds when idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

/* tb/icache_sva.sv */
/*
  bound checks on the memory strobe, the miss wait and the way hit vector
*/

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_sva (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mem_req_i,
  input  logic                 valid_i,
  input  icache_pkg::way_rsp_t rsp_i [`ICACHE_WAYS]
);
  import icache_pkg::*;

  way_oh_t hit_vec;
  // high from the cycle after a memory request until the word returns
  logic    in_miss_q;

  always_comb begin
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      hit_vec[i] = rsp_i[i].hit;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_miss_q <= 1'b0;
    end else if (mem_req_i) begin
      in_miss_q <= 1'b1;
    end else if (valid_i) begin
      in_miss_q <= 1'b0;
    end
  end

  mem_req_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i |=> !mem_req_i)
    else $error("mem_req_o high in two consecutive cycles");

  miss_no_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_miss_q |-> !(valid_i && mem_req_i))
    else $error("valid_o and mem_req_o together during a miss");

  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_vec))
    else $error("more than one way hit");

endmodule

bind icache_top icache_sva u_sva (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .mem_req_i (mem_req_o),
  .valid_i   (valid_o),
  .rsp_i     (way_rsp)
);

/* tb/tb_icache.sv */
/*
  icache testbench: clock, reset, random fetches, memory model,
  hit/miss reference model, checks and watchdog
*/

`timescale 1ns/100ps
`include "icache_defines.svh"

module tb_icache;
  import icache_pkg::*;

  localparam int    CLK_PERIOD = 20;
  localparam int    LINE_BYTES = `ICACHE_LINE_WORDS * 4;
  localparam int    MAX_LINES  = 16;
  localparam addr_t TAG_BASE   = 32'h00a3_0000;
  // low byte clear, so a step only moves tag bits
  localparam addr_t TAG_STEP   = 32'h0000_1700;
  // fetch counts per phase
  localparam int    N_SPREAD   = 200;
  localparam int    N_EVICT    = 150;
  localparam int    N_FLUSHED  = 120;
  localparam int    N_OFF      = 60;
  localparam int    N_REEN     = 60;
  localparam int    N_FETCH    = N_SPREAD + N_EVICT + N_FLUSHED + N_OFF + N_REEN;
  // lookup, worst memory wait, fill and request gaps
  localparam int    FETCH_CYC  = 24;
  localparam int    FLUSH_LIM  = `ICACHE_SETS + 8;
  localparam int    WDOG_CYC   = N_FETCH * FETCH_CYC + 4 * FLUSH_LIM + 200;
  localparam int    MUST_HIT   = 0;
  localparam int    MUST_MISS  = 1;
  localparam int    EITHER     = 2;

  logic  clk_i, rst_ni, en_i, flush_i, req_i;
  addr_t addr_i;
  logic  ready_o, valid_o, busy_o, miss_o;
  word_t data_o;
  logic  mem_req_o, mem_nc_o, mem_rtrn_vld_i;
  addr_t mem_addr_o;
  line_t mem_rtrn_line_i;

  // fetches in flight, oldest first
  addr_t exp_addr [$];
  int    exp_mode [$];
  int    exp_edge [$];
  logic  head_missed;
  // memory model
  logic  mem_pending;
  int    mem_wait;
  addr_t mem_base;
  // lines filled per set since the last flush
  addr_t seen_line [`ICACHE_SETS][MAX_LINES];
  int    seen_cnt [`ICACHE_SETS];
  addr_t last_line, last_addr;
  logic  last_valid;
  int    edge_cnt, accepted_cnt, pick_mode;

  icache_top u_icache_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // memory contents, a fixed scramble of the word address
  function automatic word_t hash_word(input addr_t a);
    word_t w;
    w = {a[15:0], a[31:16]} ^ 32'h6b43_a9b5;
    w = w * 32'h0019_660d + 32'h3c6e_f372;
    return w ^ (w >> 13);
  endfunction

  function automatic line_t line_for(input addr_t base);
    line_t l;
    for (int k = 0; k < `ICACHE_LINE_WORDS; k++) begin
      l[k] = hash_word(base + addr_t'(4 * k));
    end
    return l;
  endfunction

  function automatic addr_t make_addr(input int tag_sel, input int set, input int word);
    return TAG_BASE + addr_t'(tag_sel) * TAG_STEP + addr_t'(set * LINE_BYTES) + addr_t'(word * 4);
  endfunction

  function automatic addr_t pick_addr();
    if (last_valid && (($urandom % 8) == 0)) begin
      return last_addr;
    end
    // eviction phase crowds seven lines into set 5
    if (pick_mode == 1) begin
      return make_addr(int'($urandom % 7), 5, int'($urandom % 4));
    end
    return make_addr(int'($urandom % 4), int'($urandom % 16), int'($urandom % 4));
  endfunction

  function automatic void clear_model();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      seen_cnt[s] = 0;
    end
    last_valid = 1'b0;
  endfunction

  // classify an accepted fetch and record its line
  function automatic int predict_fetch(input addr_t a);
    addr_t line;
    int    set;
    logic  found;
    int    mode;
    line  = a / LINE_BYTES;
    set   = int'(line % `ICACHE_SETS);
    found = 1'b0;
    if (!en_i) begin
      return MUST_MISS;
    end
    for (int i = 0; i < seen_cnt[set]; i++) begin
      if (seen_line[set][i] == line) begin
        found = 1'b1;
      end
    end
    if (!found) begin
      seen_line[set][seen_cnt[set]] = line;
      seen_cnt[set]++;
      mode = MUST_MISS;
    end else if (seen_cnt[set] <= `ICACHE_WAYS || (last_valid && line == last_line)) begin
      mode = MUST_HIT;
    end else begin
      mode = EITHER;
    end
    last_line  = line;
    last_valid = 1'b1;
    return mode;
  endfunction

  ////////////////////////////////////////////////////
  // per-edge checks
  ////////////////////////////////////////////////////

  task automatic check_edge();
    addr_t exp_mem;
    edge_cnt++;
    if (busy_o && (ready_o || valid_o || mem_req_o || miss_o)) begin
      fail_run("fetch or memory strobe seen during a flush");
    end
    if (mem_rtrn_vld_i && !valid_o) begin
      fail_run("memory returned a line but valid_o stayed low");
    end
    if (mem_req_o) begin
      if (exp_addr.size() == 0) begin
        fail_run("mem_req_o with no fetch outstanding");
      end
      if (mem_pending || head_missed) begin
        fail_run("second memory request while one is in flight");
      end
      if (exp_mode[0] == MUST_HIT) begin
        fail_run("memory request for a line that should hit");
      end
      if (en_i) begin
        exp_mem = exp_addr[0] & ~addr_t'(LINE_BYTES - 1);
        if (!miss_o || mem_nc_o) begin
          fail_run("cached miss without miss_o, or marked uncached");
        end
      end else begin
        exp_mem = exp_addr[0] & ~addr_t'(3);
        if (miss_o || !mem_nc_o) begin
          fail_run("uncached fetch with miss_o high or mem_nc_o low");
        end
      end
      check_addr("mem_addr_o", mem_addr_o, exp_mem);
      head_missed = 1'b1;
      mem_pending = 1'b1;
      mem_wait    = $urandom_range(1, 8);
      mem_base    = exp_addr[0] & ~addr_t'(LINE_BYTES - 1);
    end else if (miss_o) begin
      fail_run("miss_o without a memory request");
    end
    if (valid_o) begin
      if (exp_addr.size() == 0) begin
        fail_run("valid_o with no fetch outstanding");
      end
      if (exp_mode[0] == MUST_MISS && !head_missed) begin
        fail_run("fetch hit where a miss was expected");
      end
      // hits come back two edges after the accept
      if (!head_missed && (edge_cnt - exp_edge[0]) != 2) begin
        fail_run("hit returned with the wrong latency");
      end
      check_word("data_o", data_o, hash_word(exp_addr[0]));
      void'(exp_addr.pop_front());
      void'(exp_mode.pop_front());
      void'(exp_edge.pop_front());
      head_missed = 1'b0;
    end
    if (req_i && ready_o) begin
      exp_addr.push_back(addr_i);
      exp_mode.push_back(predict_fetch(addr_i));
      exp_edge.push_back(edge_cnt);
      last_addr = addr_i;
      accepted_cnt++;
    end
  endtask

  // falling edge: memory return and the next fetch
  task automatic drive_inputs(input logic want);
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_line_i = {$urandom, $urandom, $urandom, $urandom};
    if (mem_pending) begin
      mem_wait--;
      if (mem_wait == 0) begin
        mem_rtrn_vld_i  = 1'b1;
        mem_rtrn_line_i = line_for(mem_base);
        mem_pending     = 1'b0;
      end
    end
    req_i  = want && (($urandom % 4) != 0);
    addr_i = req_i ? pick_addr() : addr_t'($urandom);
  endtask

  task automatic run_fetches(input int n, input int mode);
    accepted_cnt = 0;
    pick_mode    = mode;
    while (accepted_cnt < n || exp_addr.size() != 0 || mem_pending) begin
      drive_inputs(accepted_cnt < n);
      @(posedge clk_i);
      check_edge();
      @(negedge clk_i);
    end
    req_i          = 1'b0;
    mem_rtrn_vld_i = 1'b0;
  endtask

  task automatic wait_flush_done();
    int   n;
    logic saw_busy;
    n        = 0;
    saw_busy = 1'b0;
    @(posedge clk_i);
    while (!ready_o) begin
      if (valid_o || mem_req_o || miss_o) begin
        fail_run("fetch or memory strobe before ready_o rose");
      end
      saw_busy = saw_busy | busy_o;
      n++;
      if (n > FLUSH_LIM) begin
        fail_run("cache did not become ready after a flush");
      end
      @(posedge clk_i);
    end
    if (busy_o || !saw_busy) begin
      fail_run("busy_o did not rise and fall around the flush");
    end
    @(negedge clk_i);
  endtask

  initial begin
    void'($urandom(32'he76d_8d68));
    rst_ni          = 1'b0;
    en_i            = 1'b1;
    flush_i         = 1'b0;
    req_i           = 1'b0;
    addr_i          = '0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_line_i = '0;
    head_missed     = 1'b0;
    mem_pending     = 1'b0;
    mem_wait        = 0;
    mem_base        = '0;
    edge_cnt        = 0;
    last_addr       = '0;
    last_line       = '0;
    clear_model();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    wait_flush_done();
    // cold misses, then hits on at most four lines per set
    run_fetches(N_SPREAD, 0);
    run_fetches(N_EVICT, 1);
    flush_i = 1'b1;
    clear_model();
    @(negedge clk_i);
    flush_i = 1'b0;
    wait_flush_done();
    run_fetches(N_FLUSHED, 0);
    // disabled, every fetch goes around the arrays
    en_i = 1'b0;
    clear_model();
    run_fetches(N_OFF, 0);
    en_i = 1'b1;
    clear_model();
    wait_flush_done();
    run_fetches(N_REEN, 0);
    if (exp_addr.size() != 0 || mem_pending) begin
      fail_run("fetches still outstanding at the end of the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  // watchdog
  initial begin
    repeat (WDOG_CYC) @(posedge clk_i);
    fail_run("watchdog expired, the run did not finish in time");
  end

endmodule
